// ==== common/cfg_pkg.sv ====
// ----------------------------------------------------------------------
// Configuration loader package
// Sizes of the boot configuration path, register offsets inside a
// core's configuration space, the boot PC and the shared enums.
// ----------------------------------------------------------------------

package cfg_pkg;

  // Tile size
  localparam int CFG_NUM_CORES = 2;
  localparam int CFG_CORE_W    = 1;

  // Configuration address is {core field, register offset}
  localparam int CFG_ADDR_W       = 16;
  localparam int CFG_OFFSET_W     = 12;
  localparam int CFG_CORE_FIELD_W = CFG_ADDR_W - CFG_OFFSET_W;
  localparam int CFG_DATA_W       = 64;

  // Coherence engine microcode
  localparam int CFG_UCODE_ELS = 16;
  localparam int CFG_UCODE_AW  = 4;
  localparam int CFG_INST_W    = 32;  // low bits of the write data

  localparam int CFG_PC_W = 40;
  localparam logic [CFG_PC_W-1:0] CFG_BOOT_PC = 40'h00_8000_0000;

  // Offset of microcode word 0
  localparam logic [CFG_OFFSET_W-1:0] CFG_UCODE_BASE = 12'h800;

  // Scalar register offsets
  typedef enum logic [CFG_OFFSET_W-1:0] {
    REG_RESET    = 12'h000,
    REG_FREEZE   = 12'h001,
    REG_CORE_ID  = 12'h002,
    REG_CCE_MODE = 12'h003,
    REG_START_PC = 12'h004
  } cfg_reg_e;

  typedef enum logic [0:0] {
    CCE_MODE_UNCACHED = 1'b0,
    CCE_MODE_NORMAL   = 1'b1
  } cce_mode_e;

  // Boot sequencer steps, in program order
  typedef enum logic [3:0] {
    LOAD_INIT,
    RESET_SET,
    FREEZE_SET,
    RESET_CLR,
    SEND_CORE_ID,
    SEND_UCODE,
    SEND_CCE_MODE,
    SEND_PC,
    FREEZE_CLR,
    LOAD_DONE
  } load_state_e;

endpackage

// ==== common/cfg_cmd_if.sv ====
// ----------------------------------------------------------------------
// Configuration command channel
// One write per command, valid/yumi handshake from the boot sequencer
// to the bus stage.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

interface cfg_cmd_if;

  logic                            valid;
  logic [cfg_pkg::CFG_ADDR_W-1:0]  addr;
  logic [cfg_pkg::CFG_DATA_W-1:0]  data;
  logic                            yumi;   // Command consumed

  modport src (
    output valid,
    output addr,
    output data,
    input  yumi
  );

  modport dst (
    input  valid,
    input  addr,
    input  data,
    output yumi
  );

endinterface

// ==== cfg_loader/cfg_loader.sv ====
// ----------------------------------------------------------------------
// Boot configuration sequencer
// Walks the fixed boot program for every core: reset and freeze,
// core id, microcode copy from the boot ROM, coherence engine mode,
// start PC and freeze release. Issues one write command at a time.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module cfg_loader (
  input  logic       clk_i,
  input  logic       reset_i,
  cfg_cmd_if.src     cmd_o,
  output logic       done_o
);

  logic [cfg_pkg::CFG_INST_W-1:0] boot_rom [cfg_pkg::CFG_UCODE_ELS];

  initial $readmemh("cfg_loader/ucode.mem", boot_rom);

  cfg_pkg::load_state_e state_r, state_n;

  logic [cfg_pkg::CFG_CORE_W-1:0]   core_cnt_r;
  logic [cfg_pkg::CFG_UCODE_AW-1:0] ucode_cnt_r;
  logic                             core_last;
  logic                             ucode_last;
  logic                             group_done;

  logic [cfg_pkg::CFG_OFFSET_W-1:0] offset;
  logic [cfg_pkg::CFG_DATA_W-1:0]   data;
  logic [cfg_pkg::CFG_INST_W-1:0]   rom_data;

  assign core_last  = (int'(core_cnt_r) == cfg_pkg::CFG_NUM_CORES - 1);
  assign ucode_last = (int'(ucode_cnt_r) == cfg_pkg::CFG_UCODE_ELS - 1);

  // A scalar step ends after the last core, the microcode step after
  // the last core of the last word
  assign group_done = core_last && ((state_r != cfg_pkg::SEND_UCODE) || ucode_last);

  assign rom_data = boot_rom[ucode_cnt_r];

  // Command content and the step that follows the current one
  always_comb begin
    state_n = state_r;
    offset  = '0;
    data    = '0;
    case (state_r)
      cfg_pkg::LOAD_INIT: begin
        state_n = cfg_pkg::RESET_SET;
      end
      cfg_pkg::RESET_SET: begin
        offset  = cfg_pkg::REG_RESET;
        data[0] = 1'b1;
        state_n = cfg_pkg::FREEZE_SET;
      end
      cfg_pkg::FREEZE_SET: begin
        offset  = cfg_pkg::REG_FREEZE;
        data[0] = 1'b1;
        state_n = cfg_pkg::RESET_CLR;
      end
      cfg_pkg::RESET_CLR: begin
        offset  = cfg_pkg::REG_RESET;   // Core stays frozen
        state_n = cfg_pkg::SEND_CORE_ID;
      end
      cfg_pkg::SEND_CORE_ID: begin
        offset = cfg_pkg::REG_CORE_ID;
        data[cfg_pkg::CFG_CORE_W-1:0] = core_cnt_r;
        state_n = cfg_pkg::SEND_UCODE;
      end
      cfg_pkg::SEND_UCODE: begin
        offset = cfg_pkg::CFG_UCODE_BASE
                 + {{(cfg_pkg::CFG_OFFSET_W-cfg_pkg::CFG_UCODE_AW){1'b0}}, ucode_cnt_r};
        data[cfg_pkg::CFG_INST_W-1:0] = rom_data;
        state_n = cfg_pkg::SEND_CCE_MODE;
      end
      cfg_pkg::SEND_CCE_MODE: begin
        offset  = cfg_pkg::REG_CCE_MODE;
        data[0] = cfg_pkg::CCE_MODE_NORMAL;
        state_n = cfg_pkg::SEND_PC;
      end
      cfg_pkg::SEND_PC: begin
        offset = cfg_pkg::REG_START_PC;
        data[cfg_pkg::CFG_PC_W-1:0] = cfg_pkg::CFG_BOOT_PC;
        state_n = cfg_pkg::FREEZE_CLR;
      end
      cfg_pkg::FREEZE_CLR: begin
        offset  = cfg_pkg::REG_FREEZE;  // Core starts running
        state_n = cfg_pkg::LOAD_DONE;
      end
      cfg_pkg::LOAD_DONE: begin
        state_n = cfg_pkg::LOAD_DONE;
      end
      default: begin
        state_n = cfg_pkg::LOAD_INIT;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cfg_pkg::LOAD_INIT;
    end else if (state_r == cfg_pkg::LOAD_INIT) begin
      state_r <= state_n;
    end else if (cmd_o.yumi && group_done) begin
      state_r <= state_n;
    end
  end

  // Inner loop over cores, outer loop over microcode words
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      core_cnt_r  <= '0;
      ucode_cnt_r <= '0;
    end else if (cmd_o.yumi) begin
      core_cnt_r <= core_last ? '0 : core_cnt_r + 1'b1;
      if ((state_r == cfg_pkg::SEND_UCODE) && core_last) begin
        ucode_cnt_r <= ucode_last ? '0 : ucode_cnt_r + 1'b1;
      end
    end
  end

  assign cmd_o.valid = (state_r != cfg_pkg::LOAD_INIT) && (state_r != cfg_pkg::LOAD_DONE);
  assign cmd_o.addr  = {{(cfg_pkg::CFG_CORE_FIELD_W-cfg_pkg::CFG_CORE_W){1'b0}},
                        core_cnt_r, offset};
  assign cmd_o.data  = data;

  assign done_o = (state_r == cfg_pkg::LOAD_DONE);

endmodule

// ==== logic/wb_cfg_master.sv ====
// ----------------------------------------------------------------------
// Configuration bus master
// Captures one command and runs it as a Wishbone classic write,
// holding cyc and stb until the slave acknowledges.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module wb_cfg_master (
  input  logic                            clk_i,
  input  logic                            reset_i,
  cfg_cmd_if.dst                          cmd_i,
  output logic                            wb_cyc_o,
  output logic                            wb_stb_o,
  output logic                            wb_we_o,
  output logic [cfg_pkg::CFG_ADDR_W-1:0]  wb_adr_o,
  output logic [cfg_pkg::CFG_DATA_W-1:0]  wb_dat_o,
  input  logic                            wb_ack_i
);

  typedef enum logic {
    WB_IDLE,
    WB_BUSY
  } wb_state_e;

  wb_state_e state_r;

  logic [cfg_pkg::CFG_ADDR_W-1:0] adr_r;
  logic [cfg_pkg::CFG_DATA_W-1:0] dat_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= WB_IDLE;
    end else begin
      case (state_r)
        WB_IDLE: if (cmd_i.valid) state_r <= WB_BUSY;
        WB_BUSY: if (wb_ack_i) state_r <= WB_IDLE;
        default: state_r <= WB_IDLE;
      endcase
    end
  end

  // Command payload, held for the whole cycle
  always_ff @(posedge clk_i) begin
    if ((state_r == WB_IDLE) && cmd_i.valid) begin
      adr_r <= cmd_i.addr;
      dat_r <= cmd_i.data;
    end
  end

  assign wb_cyc_o = (state_r == WB_BUSY);
  assign wb_stb_o = (state_r == WB_BUSY);
  assign wb_we_o  = 1'b1;             // Write only bus
  assign wb_adr_o = adr_r;
  assign wb_dat_o = dat_r;

  assign cmd_i.yumi = (state_r == WB_BUSY) && wb_ack_i;

endmodule

// ==== logic/core_cfg_regs.sv ====
// ----------------------------------------------------------------------
// Per-core configuration registers
// Wishbone slave at the end of the configuration path. Holds reset,
// freeze, core id, coherence engine mode, start PC and the microcode
// RAM of every core, and drives the cores' control outputs.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module core_cfg_regs (
  input  logic                                                     clk_i,
  input  logic                                                     reset_i,
  input  logic                                                     wb_cyc_i,
  input  logic                                                     wb_stb_i,
  input  logic                                                     wb_we_i,
  input  logic [cfg_pkg::CFG_ADDR_W-1:0]                           wb_adr_i,
  input  logic [cfg_pkg::CFG_DATA_W-1:0]                           wb_dat_i,
  output logic                                                     wb_ack_o,
  input  logic                                                     stall_i,
  output logic [cfg_pkg::CFG_NUM_CORES-1:0]                        core_reset_o,
  output logic [cfg_pkg::CFG_NUM_CORES-1:0]                        core_freeze_o,
  output logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_CORE_W-1:0]    core_id_o,
  output cfg_pkg::cce_mode_e [cfg_pkg::CFG_NUM_CORES-1:0]          cce_mode_o,
  output logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_PC_W-1:0]      start_pc_o,
  input  logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_UCODE_AW-1:0]  ucode_addr_i,
  output logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_INST_W-1:0]    ucode_data_o
);

  logic [cfg_pkg::CFG_NUM_CORES-1:0]                          reset_r;
  logic [cfg_pkg::CFG_NUM_CORES-1:0]                          freeze_r;
  logic [cfg_pkg::CFG_NUM_CORES-1:0][cfg_pkg::CFG_CORE_W-1:0] core_id_r;
  logic [cfg_pkg::CFG_NUM_CORES-1:0][cfg_pkg::CFG_PC_W-1:0]   start_pc_r;
  cfg_pkg::cce_mode_e [cfg_pkg::CFG_NUM_CORES-1:0]            cce_mode_r;

  logic [cfg_pkg::CFG_INST_W-1:0] ucode_ram [cfg_pkg::CFG_NUM_CORES][cfg_pkg::CFG_UCODE_ELS];

  logic [cfg_pkg::CFG_CORE_FIELD_W-1:0] core_field;
  logic [cfg_pkg::CFG_CORE_W-1:0]       core_sel;
  logic [cfg_pkg::CFG_OFFSET_W-1:0]     offset;
  logic [cfg_pkg::CFG_OFFSET_W-1:0]     ucode_off;
  logic                                 core_ok;
  logic                                 wr_en;
  logic                                 reg_we;
  logic                                 ram_we;
  logic                                 ack_r;

  assign core_field = wb_adr_i[cfg_pkg::CFG_ADDR_W-1:cfg_pkg::CFG_OFFSET_W];
  assign core_sel   = core_field[cfg_pkg::CFG_CORE_W-1:0];
  assign offset     = wb_adr_i[cfg_pkg::CFG_OFFSET_W-1:0];
  assign ucode_off  = offset - cfg_pkg::CFG_UCODE_BASE;   // Wraps below the base
  assign core_ok    = int'(core_field) < cfg_pkg::CFG_NUM_CORES;

  // One write per bus cycle, on the edge that raises ack
  assign wr_en  = wb_cyc_i && wb_stb_i && wb_we_i && !stall_i && !ack_r;
  assign reg_we = wr_en && core_ok;
  assign ram_we = reg_we && (int'(ucode_off) < cfg_pkg::CFG_UCODE_ELS);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= wb_cyc_i && wb_stb_i && !stall_i && !ack_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < cfg_pkg::CFG_NUM_CORES; i++) begin
        reset_r[i]    <= 1'b1;  // Cores held until the loader lets go
        freeze_r[i]   <= 1'b1;
        core_id_r[i]  <= '0;
        start_pc_r[i] <= '0;
        cce_mode_r[i] <= cfg_pkg::CCE_MODE_UNCACHED;
      end
    end else if (reg_we) begin
      case (offset)
        cfg_pkg::REG_RESET:    reset_r[core_sel]    <= wb_dat_i[0];
        cfg_pkg::REG_FREEZE:   freeze_r[core_sel]   <= wb_dat_i[0];
        cfg_pkg::REG_CORE_ID:  core_id_r[core_sel]  <= wb_dat_i[cfg_pkg::CFG_CORE_W-1:0];
        cfg_pkg::REG_CCE_MODE: cce_mode_r[core_sel] <= cfg_pkg::cce_mode_e'(wb_dat_i[0]);
        cfg_pkg::REG_START_PC: start_pc_r[core_sel] <= wb_dat_i[cfg_pkg::CFG_PC_W-1:0];
        default: ;  // Unknown offsets are acked and dropped
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ram_we) begin
      ucode_ram[core_sel][ucode_off[cfg_pkg::CFG_UCODE_AW-1:0]] <=
        wb_dat_i[cfg_pkg::CFG_INST_W-1:0];
    end
  end

  // Combinational microcode read per core
  for (genvar c = 0; c < cfg_pkg::CFG_NUM_CORES; c++) begin : g_ucode_rd
    assign ucode_data_o[c*cfg_pkg::CFG_INST_W +: cfg_pkg::CFG_INST_W] =
      ucode_ram[c][ucode_addr_i[c*cfg_pkg::CFG_UCODE_AW +: cfg_pkg::CFG_UCODE_AW]];
  end

  assign wb_ack_o      = ack_r;
  assign core_reset_o  = reset_r;
  assign core_freeze_o = freeze_r;
  assign core_id_o     = core_id_r;
  assign cce_mode_o    = cce_mode_r;
  assign start_pc_o    = start_pc_r;

endmodule

// ==== logic/cfg_subsystem.sv ====
// ----------------------------------------------------------------------
// Boot configuration subsystem
// Sequencer, Wishbone bus stage and per-core configuration registers
// in a chain. done_o marks the end of the boot load.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module cfg_subsystem (
  input  logic                                                     clk_i,
  input  logic                                                     reset_i,
  input  logic                                                     cfg_stall_i,
  output logic                                                     done_o,
  output logic [cfg_pkg::CFG_NUM_CORES-1:0]                        core_reset_o,
  output logic [cfg_pkg::CFG_NUM_CORES-1:0]                        core_freeze_o,
  output logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_CORE_W-1:0]    core_id_o,
  output cfg_pkg::cce_mode_e [cfg_pkg::CFG_NUM_CORES-1:0]          cce_mode_o,
  output logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_PC_W-1:0]      start_pc_o,
  input  logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_UCODE_AW-1:0]  ucode_addr_i,
  output logic [cfg_pkg::CFG_NUM_CORES*cfg_pkg::CFG_INST_W-1:0]    ucode_data_o
);

  cfg_cmd_if cmd_if ();

  // Wishbone classic, write only
  logic                           wb_cyc;
  logic                           wb_stb;
  logic                           wb_we;
  logic [cfg_pkg::CFG_ADDR_W-1:0] wb_adr;
  logic [cfg_pkg::CFG_DATA_W-1:0] wb_dat;
  logic                           wb_ack;

  cfg_loader u_loader (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd_o   (cmd_if.src),
    .done_o  (done_o)
  );

  wb_cfg_master u_master (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cmd_i    (cmd_if.dst),
    .wb_cyc_o (wb_cyc),
    .wb_stb_o (wb_stb),
    .wb_we_o  (wb_we),
    .wb_adr_o (wb_adr),
    .wb_dat_o (wb_dat),
    .wb_ack_i (wb_ack)
  );

  core_cfg_regs u_regs (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat),
    .wb_ack_o      (wb_ack),
    .stall_i       (cfg_stall_i),
    .core_reset_o  (core_reset_o),
    .core_freeze_o (core_freeze_o),
    .core_id_o     (core_id_o),
    .cce_mode_o    (cce_mode_o),
    .start_pc_o    (start_pc_o),
    .ucode_addr_i  (ucode_addr_i),
    .ucode_data_o  (ucode_data_o)
  );

endmodule

// ==== tb/cfg_subsystem_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for the boot configuration subsystem
// Directed tests of reset state, full load, microcode contents, write
// ordering, random back-pressure and restart in the middle of a load.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module cfg_subsystem_tb;

  localparam int num_cores       = cfg_pkg::CFG_NUM_CORES;
  localparam int ucode_els       = cfg_pkg::CFG_UCODE_ELS;
  localparam int core_w          = cfg_pkg::CFG_CORE_W;
  localparam int pc_w            = cfg_pkg::CFG_PC_W;
  localparam int aw              = cfg_pkg::CFG_UCODE_AW;
  localparam int inst_w          = cfg_pkg::CFG_INST_W;
  localparam int writes_per_load = num_cores * (7 + ucode_els);  // Seven scalar writes per core
  localparam int watchdog_cycles = 6 * 46 * 40;  // Tests x writes x cycles per write

  logic                               clk_i;
  logic                               reset_i;
  logic                               cfg_stall_i;
  logic                               done_o;
  logic [num_cores-1:0]               core_reset_o;
  logic [num_cores-1:0]               core_freeze_o;
  logic [num_cores*core_w-1:0]        core_id_o;
  cfg_pkg::cce_mode_e [num_cores-1:0] cce_mode_o;
  logic [num_cores*pc_w-1:0]          start_pc_o;
  logic [num_cores*aw-1:0]            ucode_addr_i;
  logic [num_cores*inst_w-1:0]        ucode_data_o;

  logic [inst_w-1:0] exp_ucode [ucode_els];
  logic [15:0]       lfsr_r;
  int                errors;
  int                tests_run;
  int                tests_failed;
  int                plain_cycles;

  cfg_subsystem dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cfg_stall_i   (cfg_stall_i),
    .done_o        (done_o),
    .core_reset_o  (core_reset_o),
    .core_freeze_o (core_freeze_o),
    .core_id_o     (core_id_o),
    .cce_mode_o    (cce_mode_o),
    .start_pc_o    (start_pc_o),
    .ucode_addr_i  (ucode_addr_i),
    .ucode_data_o  (ucode_data_o)
  );

  always #50 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
      $display("Test %0d (%s): ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d (%s): %0d check(s) wrong", tests_run, name, errors - mark);
    end
  endtask

  task automatic check_reset_outputs(input string when);
    check_value({"done_o ", when}, 64'(done_o), 64'h0);
    for (int k = 0; k < num_cores; k++) begin
      check_value($sformatf("core_reset_o[%0d] %s", k, when), 64'(core_reset_o[k]), 64'h1);
      check_value($sformatf("core_freeze_o[%0d] %s", k, when), 64'(core_freeze_o[k]), 64'h1);
      check_value($sformatf("cce_mode_o[%0d] %s", k, when), 64'(cce_mode_o[k]), 64'h0);
      check_value($sformatf("start_pc_o[%0d] %s", k, when),
                  64'(start_pc_o[k*pc_w +: pc_w]), 64'h0);
    end
  endtask

  // Holds reset for two cycles and can check the outputs in and right after it
  task automatic apply_reset(input bit check_outputs);
    if (!reset_i) begin
      @(posedge clk_i);
      reset_i <= 1'b1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    if (check_outputs) check_reset_outputs("in reset");
    @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    if (check_outputs) check_reset_outputs("after reset");
  endtask

  task automatic wait_done(input bit use_stall, output int cycles);
    int acks;
    cycles = 0;
    acks   = 0;
    do begin
      @(posedge clk_i);
      if (use_stall) begin
        lfsr_r = lfsr_step(lfsr_r);
        cfg_stall_i <= lfsr_r[0];
      end
      @(negedge clk_i);
      if (dut.wb_ack) acks++;
      cycles++;
    end while (!done_o);
    check_value("wb_ack pulses", 64'(acks), 64'(writes_per_load));
    if (use_stall) begin
      @(posedge clk_i);
      cfg_stall_i <= 1'b0;
    end
  endtask

  task automatic check_final_regs();
    for (int k = 0; k < num_cores; k++) begin
      check_value($sformatf("core_reset_o[%0d]", k), 64'(core_reset_o[k]), 64'h0);
      check_value($sformatf("core_freeze_o[%0d]", k), 64'(core_freeze_o[k]), 64'h0);
      check_value($sformatf("core_id_o[%0d]", k), 64'(core_id_o[k*core_w +: core_w]), 64'(k));
      check_value($sformatf("cce_mode_o[%0d]", k), 64'(cce_mode_o[k]), 64'h1);
      check_value($sformatf("start_pc_o[%0d]", k),
                  64'(start_pc_o[k*pc_w +: pc_w]), 64'(cfg_pkg::CFG_BOOT_PC));
    end
  endtask

  // Odd cores read the image backwards to catch crossed read ports
  task automatic verify_ucode();
    logic [num_cores*aw-1:0] addr_vec;
    int                      idx;
    for (int i = 0; i < ucode_els; i++) begin
      for (int c = 0; c < num_cores; c++) begin
        addr_vec[c*aw +: aw] = aw'((c % 2 == 0) ? i : ucode_els - 1 - i);
      end
      @(posedge clk_i);
      ucode_addr_i <= addr_vec;
      @(negedge clk_i);
      for (int c = 0; c < num_cores; c++) begin
        idx = (c % 2 == 0) ? i : ucode_els - 1 - i;
        check_value($sformatf("ucode_data_o[%0d][%0d]", c, idx),
                    64'(ucode_data_o[c*inst_w +: inst_w]), 64'(exp_ucode[idx]));
      end
    end
  endtask

  task automatic check_reset_behavior();
    int mark;
    mark = errors;
    apply_reset(1'b1);
    report_test("reset state", mark);
  endtask

  task automatic run_plain_load();
    int mark;
    mark = errors;
    wait_done(1'b0, plain_cycles);
    check_final_regs();
    report_test($sformatf("full load, %0d cycles", plain_cycles), mark);
  endtask

  task automatic read_back_ucode();
    int mark;
    mark = errors;
    verify_ucode();
    report_test("microcode contents", mark);
  endtask

  task automatic watch_release_order();
    logic [num_cores-1:0]      prev_reset;
    logic [num_cores-1:0]      prev_freeze;
    logic [num_cores*pc_w-1:0] prev_pc;
    int                        mark;
    int                        falls;
    mark  = errors;
    falls = 0;
    apply_reset(1'b0);
    prev_reset  = core_reset_o;
    prev_freeze = core_freeze_o;
    prev_pc     = start_pc_o;
    while (!done_o) begin
      @(negedge clk_i);
      for (int k = 0; k < num_cores; k++) begin
        if (prev_freeze[k] && !core_freeze_o[k]) begin
          falls++;
          check_true(prev_pc[k*pc_w +: pc_w] == cfg_pkg::CFG_BOOT_PC,
                     $sformatf("core %0d unfrozen before its start PC was set", k));
        end
        if (prev_reset[k] && !core_reset_o[k]) begin
          falls++;
          check_true(core_freeze_o[k], $sformatf("core %0d left reset while not frozen", k));
        end
      end
      prev_reset  = core_reset_o;
      prev_freeze = core_freeze_o;
      prev_pc     = start_pc_o;
    end
    check_value("reset and freeze releases", 64'(falls), 64'(2 * num_cores));
    report_test("release ordering", mark);
  endtask

  task automatic run_stalled_load();
    int mark;
    int cycles;
    mark = errors;
    apply_reset(1'b0);
    wait_done(1'b1, cycles);
    check_true(cycles > plain_cycles, "random stall did not lengthen the load");
    check_final_regs();
    verify_ucode();
    report_test($sformatf("back-pressure, %0d cycles", cycles), mark);
  endtask

  task automatic restart_mid_load();
    string state_name;
    int    mark;
    int    cycles;
    mark = errors;
    apply_reset(1'b0);
    repeat (60) @(negedge clk_i);
    check_true(!done_o, "load already finished at the restart point");
    check_true(core_reset_o != '1, "load had not reached reset release before restart");
    state_name = dut.u_loader.state_r.name();
    apply_reset(1'b1);
    wait_done(1'b0, cycles);
    check_final_regs();
    verify_ucode();
    report_test($sformatf("restart from %s", state_name), mark);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Error: watchdog expired after %0d cycles", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    cfg_stall_i  = 1'b0;
    ucode_addr_i = '0;
    lfsr_r       = 16'd16;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    plain_cycles = 0;
    $readmemh("cfg_loader/ucode.mem", exp_ucode);

    check_reset_behavior();
    run_plain_load();
    read_back_ucode();
    watch_release_order();
    run_stalled_load();
    restart_mid_load();

    $display("Summary: %0d tests, %0d with errors, %0d failed checks",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== cfg_loader/ucode.mem ====
// Coherence engine microcode: one 32-bit instruction in hex per line, word 0 first
08100000
0c204001
10308012
1440c023
18510034
1c614045
20718056
2481c067
28920078
2ca24089
30b2809a
34c2c0ab
38d300bc
3ce340cd
40f380de
7c0000ff

// ==== cfg_subsystem.f ====
common/cfg_pkg.sv
common/cfg_cmd_if.sv
cfg_loader/cfg_loader.sv
logic/wb_cfg_master.sv
logic/core_cfg_regs.sv
logic/cfg_subsystem.sv
tb/cfg_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cfg_subsystem_tb -f cfg_subsystem.f -o cfg_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

output=$(./obj_dir/cfg_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
